//--- compile.f
kd_trav_pkg.sv
sync_fifo.sv
trav_node_dispatch.sv
trav_slab_math.sv
trav_decide.sv
kd_trav_top.sv
tb_clk_gen.sv
kd_trav_tb.sv

//--- kd_trav_pkg.sv
//--------------------------------------------------
// kd-tree traversal shared types
// node word views, ray state, stage and output
// words, Q8.8 fixed-point helpers
//--------------------------------------------------
package kd_trav_pkg;

  typedef logic signed [15:0] fix_t;       // Q8.8
  typedef logic signed [16:0] fix_wide_t;  // difference of two fix_t
  typedef logic [11:0]        node_id_t;

  localparam logic [1:0] NODE_LEAF    = 2'd3;
  localparam logic [2:0] SS_DEPTH_MAX = 3'd4;

  //--------------------------------------------------
  // node word, decoded as inner or as leaf
  //--------------------------------------------------
  typedef struct packed {
    logic [1:0] node_type;  // split axis, 0..2
    fix_t       split;
    node_id_t   right_id;
    logic       low_empty;
    logic       high_empty;
  } inner_node_t;

  typedef struct packed {
    logic [1:0]  node_type;  // always NODE_LEAF
    logic [19:0] tri_ptr;
    logic [9:0]  tri_count;
  } leaf_node_t;

  typedef union packed {
    inner_node_t inner;
    leaf_node_t  leaf;
  } tree_node_u;

  typedef struct packed {
    logic [7:0] ray_id;
    logic       is_shadow;
    logic [2:0] ss_num;  // short stack depth
  } ray_info_t;

  typedef struct packed {
    ray_info_t  ray_info;
    node_id_t   node_id;
    tree_node_u node;
    fix_t       origin;   // along split axis
    fix_t       inv_dir;
    fix_t       t_min;
    fix_t       t_max;
  } node_req_t;

  typedef struct packed {
    ray_info_t ray_info;
    node_id_t  parent_id;
    node_id_t  right_id;
    logic      low_empty;
    logic      high_empty;
    fix_t      t_min;
    fix_t      t_mid;
    fix_t      t_max;
    logic      only_low;
    logic      only_high;
    logic      lo_then_hi;
    logic      hi_then_lo;
  } slab_res_t;

  typedef struct packed {
    ray_info_t   ray_info;
    logic [19:0] tri_ptr;
    logic [9:0]  tri_count;
    fix_t        t_max;
  } leaf_out_t;

  typedef struct packed {
    ray_info_t ray_info;
    logic      push_req;
    logic      pop_req;
    node_id_t  push_node_id;
    fix_t      push_t_min;
    fix_t      push_t_max;
  } stack_cmd_t;

  typedef struct packed {
    ray_info_t ray_info;
    node_id_t  node_id;
    fix_t      t_min;
    fix_t      t_max;
  } next_node_t;

  //--------------------------------------------------
  // fixed-point helpers
  //--------------------------------------------------
  function automatic fix_wide_t fix_diff(input fix_t a, input fix_t b);
    return fix_wide_t'(a) - fix_wide_t'(b);  // 17 bits, cannot overflow
  endfunction

  // Q8.8 times Q8.8, back to Q8.8 with clamping
  function automatic fix_t fix_mul_sat(input fix_wide_t a, input fix_t b);
    logic signed [32:0] prod;
    logic signed [32:0] shifted;
    fix_t               res;
    prod    = a * b;
    shifted = prod >>> 8;
    if (shifted > 33'sd32767) begin
      res = 16'sh7fff;
    end else if (shifted < -33'sd32768) begin
      res = 16'sh8000;
    end else begin
      res = fix_t'(shifted);
    end
    return res;
  endfunction

endpackage

//--- kd_trav_tb.sv
//--------------------------------------------------
// kd-tree traversal testbench
// table of node requests with expected leaf, stack
// and next-node words, random output back-pressure
//--------------------------------------------------
module kd_trav_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import kd_trav_pkg::*;

  localparam int NUM_ENTRIES    = 16;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 20 + 100;

  typedef struct packed {
    node_req_t  req;
    logic       has_leaf;
    logic       has_stack;
    logic       has_next;
    leaf_out_t  leaf;
    stack_cmd_t stack;
    next_node_t next;
  } tab_entry_t;

  logic       clk;
  logic       rst_n;
  logic       node_valid;
  node_req_t  node_data;
  logic       node_stall;
  logic       leaf_valid;
  leaf_out_t  leaf_data;
  logic       leaf_stall;
  logic       stack_valid;
  stack_cmd_t stack_data;
  logic       stack_stall;
  logic       next_valid;
  next_node_t next_data;
  logic       next_stall;

  tab_entry_t  tab [NUM_ENTRIES];
  int          n_ent;
  int          errors;
  int          n_checks;
  int          cycles;
  integer      seed;
  logic [31:0] stall_bits;
  leaf_out_t   leaf_exp_q[$];
  stack_cmd_t  stack_exp_q[$];
  next_node_t  next_exp_q[$];

  tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(3)) clk_gen_i (.clk, .rst_n);

  kd_trav_top #(.LEAF_DEPTH(8), .DEC_DEPTH(8)) dut_i (
    .clk, .rst_n,
    .node_valid, .node_data, .node_stall,
    .leaf_valid, .leaf_data, .leaf_stall,
    .stack_valid, .stack_data, .stack_stall,
    .next_valid, .next_data, .next_stall
  );

  //--------------------------------------------------
  // table building
  //--------------------------------------------------
  function automatic ray_info_t ray_state(input logic [7:0] id, input logic shadow,
                                          input logic [2:0] ss);
    ray_info_t r;
    r.ray_id    = id;
    r.is_shadow = shadow;
    r.ss_num    = ss;
    return r;
  endfunction

  task automatic add_leaf(input ray_info_t ri, input logic [19:0] ptr,
                          input logic [9:0] cnt, input fix_t t_max);
    tab_entry_t e;
    e                          = '0;
    e.req.ray_info             = ri;
    e.req.node.leaf.node_type  = NODE_LEAF;
    e.req.node.leaf.tri_ptr    = ptr;
    e.req.node.leaf.tri_count  = cnt;
    e.req.t_max                = t_max;
    e.has_leaf                 = 1'b1;
    e.leaf.ray_info            = ri;
    e.leaf.tri_ptr             = ptr;
    e.leaf.tri_count           = cnt;
    e.leaf.t_max               = t_max;
    tab[n_ent] = e;
    n_ent++;
  endtask

  task automatic add_inner(input ray_info_t ri, input node_id_t id, input fix_t split,
                           input node_id_t right, input logic lo_e, input logic hi_e,
                           input fix_t origin, input fix_t inv_dir,
                           input fix_t t_min, input fix_t t_max);
    tab_entry_t e;
    e                          = '0;
    e.req.ray_info             = ri;
    e.req.node_id              = id;
    e.req.node.inner.node_type = 2'(n_ent % 3);  // any split axis
    e.req.node.inner.split     = split;
    e.req.node.inner.right_id  = right;
    e.req.node.inner.low_empty = lo_e;
    e.req.node.inner.high_empty = hi_e;
    e.req.origin               = origin;
    e.req.inv_dir              = inv_dir;
    e.req.t_min                = t_min;
    e.req.t_max                = t_max;
    tab[n_ent] = e;
    n_ent++;
  endtask

  // expectations attach to the last entry added
  task automatic expect_next(input node_id_t id, input logic [2:0] ss,
                             input fix_t t_min, input fix_t t_max);
    tab[n_ent-1].has_next             = 1'b1;
    tab[n_ent-1].next.ray_info        = tab[n_ent-1].req.ray_info;
    tab[n_ent-1].next.ray_info.ss_num = ss;
    tab[n_ent-1].next.node_id         = id;
    tab[n_ent-1].next.t_min           = t_min;
    tab[n_ent-1].next.t_max           = t_max;
  endtask

  task automatic expect_push(input node_id_t id, input fix_t t_min, input fix_t t_max);
    tab[n_ent-1].has_stack          = 1'b1;
    tab[n_ent-1].stack.ray_info     = tab[n_ent-1].req.ray_info;
    tab[n_ent-1].stack.push_req     = 1'b1;
    tab[n_ent-1].stack.push_node_id = id;
    tab[n_ent-1].stack.push_t_min   = t_min;
    tab[n_ent-1].stack.push_t_max   = t_max;
  endtask

  task automatic expect_pop();
    tab[n_ent-1].has_stack      = 1'b1;
    tab[n_ent-1].stack.ray_info = tab[n_ent-1].req.ray_info;
    tab[n_ent-1].stack.pop_req  = 1'b1;
  endtask

  task automatic build_table();
    n_ent = 0;
    add_leaf(ray_state(8'd1, 1'b0, 3'd0), 20'h00100, 10'd5, 16'h0400);
    // t_mid 2.0 past t_max with the low child near
    add_inner(ray_state(8'd2, 1'b0, 3'd0), 12'h010, 16'h0300, 12'h0a0, 1'b0, 1'b0,
              16'h0100, 16'h0100, 16'h0000, 16'h0180);
    expect_next(12'h011, 3'd0, 16'h0000, 16'h0180);
    add_inner(ray_state(8'd3, 1'b0, 3'd0), 12'h018, 16'h0200, 12'h050, 1'b0, 1'b0,
              16'h0100, 16'h0100, 16'h0100, 16'h0300);
    expect_next(12'h050, 3'd0, 16'h0100, 16'h0300);  // far is high
    // negative direction puts the high child near
    add_inner(ray_state(8'd4, 1'b0, 3'd0), 12'h020, 16'h0100, 12'h060, 1'b0, 1'b0,
              16'h0300, 16'hff00, 16'h0000, 16'h0100);
    expect_next(12'h060, 3'd0, 16'h0000, 16'h0100);
    add_inner(ray_state(8'd5, 1'b0, 3'd0), 12'h030, 16'h0200, 12'h0b0, 1'b0, 1'b0,
              16'h0300, 16'hff00, 16'h0100, 16'h0400);
    expect_next(12'h031, 3'd0, 16'h0100, 16'h0400);
    // origin on the plane gives t_mid 0
    add_inner(ray_state(8'd6, 1'b0, 3'd0), 12'h040, 16'h0200, 12'h070, 1'b0, 1'b0,
              16'h0200, 16'h0080, 16'h0000, 16'h0200);
    expect_next(12'h070, 3'd0, 16'h0000, 16'h0200);
    add_inner(ray_state(8'd7, 1'b0, 3'd0), 12'h048, 16'h0200, 12'h0c0, 1'b0, 1'b0,
              16'h0200, 16'hff80, 16'h0000, 16'h0200);
    expect_next(12'h049, 3'd0, 16'h0000, 16'h0200);
    add_leaf(ray_state(8'd8, 1'b1, 3'd2), 20'hfedcb, 10'd1023, 16'h1234);
    // both children with a push of the far one
    add_inner(ray_state(8'd9, 1'b0, 3'd1), 12'h050, 16'h0200, 12'h080, 1'b0, 1'b0,
              16'h0000, 16'h0100, 16'h0100, 16'h0400);
    expect_push(12'h080, 16'h0200, 16'h0400);
    expect_next(12'h051, 3'd2, 16'h0100, 16'h0200);
    add_inner(ray_state(8'd10, 1'b1, 3'd4), 12'h058, 16'h0200, 12'h090, 1'b0, 1'b0,
              16'h0400, 16'hff00, 16'h0000, 16'h0300);
    expect_push(12'h059, 16'h0200, 16'h0300);
    expect_next(12'h090, 3'd4, 16'h0000, 16'h0200);  // depth stays at 4
    // single chosen child empty
    add_inner(ray_state(8'd11, 1'b0, 3'd2), 12'h060, 16'h0300, 12'h0d0, 1'b1, 1'b0,
              16'h0100, 16'h0100, 16'h0000, 16'h0180);
    expect_pop();
    add_inner(ray_state(8'd12, 1'b0, 3'd3), 12'h068, 16'h0200, 12'h0e0, 1'b0, 1'b1,
              16'h0100, 16'h0100, 16'h0100, 16'h0300);
    expect_pop();
    // both children chosen but one empty
    add_inner(ray_state(8'd13, 1'b0, 3'd1), 12'h070, 16'h0200, 12'h0f0, 1'b1, 1'b0,
              16'h0000, 16'h0100, 16'h0100, 16'h0400);
    expect_next(12'h0f0, 3'd1, 16'h0200, 16'h0400);
    add_inner(ray_state(8'd14, 1'b0, 3'd2), 12'h078, 16'h0200, 12'h100, 1'b0, 1'b1,
              16'h0400, 16'hff00, 16'h0000, 16'h0300);
    expect_next(12'h079, 3'd2, 16'h0200, 16'h0300);
    // 65.0 * 4.0 clamps to 0x7fff and only near is taken
    // a wrapped product of 4.0 would take both
    add_inner(ray_state(8'd15, 1'b0, 3'd0), 12'h080, 16'h4100, 12'h110, 1'b0, 1'b0,
              16'h0000, 16'h0400, 16'h0100, 16'h7000);
    expect_next(12'h081, 3'd0, 16'h0100, 16'h7000);
    add_leaf(ray_state(8'd16, 1'b0, 3'd1), 20'h00abc, 10'd3, 16'h0200);
  endtask

  //--------------------------------------------------
  // checking
  //--------------------------------------------------
  function automatic int words_pending();
    return leaf_exp_q.size() + stack_exp_q.size() + next_exp_q.size();
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_leaf(input leaf_out_t got);
    leaf_out_t exp;
    assert (leaf_exp_q.size() > 0) else begin
      errors++;
      $display("unexpected word on the leaf output at %0t ns", $time);
    end
    if (leaf_exp_q.size() > 0) begin
      exp = leaf_exp_q.pop_front();
      check_value("leaf_data.ray_info", got.ray_info, exp.ray_info);
      check_value("leaf_data.tri_ptr", got.tri_ptr, exp.tri_ptr);
      check_value("leaf_data.tri_count", got.tri_count, exp.tri_count);
      check_value("leaf_data.t_max", got.t_max, exp.t_max);
    end
  endtask

  task automatic check_stack(input stack_cmd_t got);
    stack_cmd_t exp;
    assert (stack_exp_q.size() > 0) else begin
      errors++;
      $display("unexpected word on the stack output at %0t ns", $time);
    end
    if (stack_exp_q.size() > 0) begin
      exp = stack_exp_q.pop_front();
      check_value("stack_data.ray_info", got.ray_info, exp.ray_info);
      check_value("stack_data.push_req", got.push_req, exp.push_req);
      check_value("stack_data.pop_req", got.pop_req, exp.pop_req);
      if (exp.push_req) begin  // pop carries no node
        check_value("stack_data.push_node_id", got.push_node_id, exp.push_node_id);
        check_value("stack_data.push_t_min", got.push_t_min, exp.push_t_min);
        check_value("stack_data.push_t_max", got.push_t_max, exp.push_t_max);
      end
    end
  endtask

  task automatic check_next(input next_node_t got);
    next_node_t exp;
    assert (next_exp_q.size() > 0) else begin
      errors++;
      $display("unexpected word on the next-node output at %0t ns", $time);
    end
    if (next_exp_q.size() > 0) begin
      exp = next_exp_q.pop_front();
      check_value("next_data.ray_info", got.ray_info, exp.ray_info);
      check_value("next_data.node_id", got.node_id, exp.node_id);
      check_value("next_data.t_min", got.t_min, exp.t_min);
      check_value("next_data.t_max", got.t_max, exp.t_max);
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      if (leaf_valid && !leaf_stall) check_leaf(leaf_data);
      if (stack_valid && !stack_stall) check_stack(stack_data);
      if (next_valid && !next_stall) check_next(next_data);
    end
  end

  // random back-pressure on all three outputs
  always @(posedge clk) begin
    stall_bits = $random(seed);
    leaf_stall  <= stall_bits[0];
    stack_stall <= stall_bits[1];
    next_stall  <= stall_bits[2];
  end

  //--------------------------------------------------
  // stimulus and end of run
  //--------------------------------------------------
  initial begin
    seed        = 32'h7ecc_0717;
    errors      = 0;
    n_checks    = 0;
    node_valid  = 1'b0;
    node_data   = '0;
    leaf_stall  = 1'b0;
    stack_stall = 1'b0;
    next_stall  = 1'b0;
    build_table();
    wait (rst_n);
    @(posedge clk);
    for (int i = 0; i < n_ent; i++) begin
      node_valid <= 1'b1;
      node_data  <= tab[i].req;
      if (tab[i].has_leaf) leaf_exp_q.push_back(tab[i].leaf);
      if (tab[i].has_stack) stack_exp_q.push_back(tab[i].stack);
      if (tab[i].has_next) next_exp_q.push_back(tab[i].next);
      @(posedge clk);
      while (node_stall) @(posedge clk);  // hold until accepted
    end
    node_valid <= 1'b0;
    while (words_pending() != 0) @(posedge clk);
    repeat (8) @(posedge clk);  // room for stray words
    assert (words_pending() == 0 && !leaf_valid && !stack_valid && !next_valid) else begin
      errors++;
      $display("an output still holds a word after the last expected one");
    end
    $display("checks %0d, errors %0d", n_checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    errors++;
    $display("timeout after %0d cycles with %0d words still expected",
             cycles, words_pending());
    $display("checks %0d, errors %0d", n_checks, errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- kd_trav_top.sv
//--------------------------------------------------
// kd-tree traversal stage
// dispatch, slab math and decide in a pipeline
//--------------------------------------------------
module kd_trav_top #(
  parameter int LEAF_DEPTH = 8,
  parameter int DEC_DEPTH  = 8
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    node_valid,
  input  kd_trav_pkg::node_req_t  node_data,
  output logic                    node_stall,
  output logic                    leaf_valid,
  output kd_trav_pkg::leaf_out_t  leaf_data,
  input  logic                    leaf_stall,
  output logic                    stack_valid,
  output kd_trav_pkg::stack_cmd_t stack_data,
  input  logic                    stack_stall,
  output logic                    next_valid,
  output kd_trav_pkg::next_node_t next_data,
  input  logic                    next_stall
);
  import kd_trav_pkg::*;

  logic      inner_valid;
  node_req_t inner_data;
  logic      inner_stall;
  logic      slab_valid;
  slab_res_t slab_data;
  logic      slab_stall;

  trav_node_dispatch #(.LEAF_DEPTH(LEAF_DEPTH)) dispatch_i (
    .clk, .rst_n,
    .node_valid, .node_data, .node_stall,
    .inner_valid, .inner_data, .inner_stall,
    .leaf_valid, .leaf_data, .leaf_stall
  );

  trav_slab_math slab_i (
    .clk, .rst_n,
    .inner_valid, .inner_data, .inner_stall,
    .slab_valid, .slab_data, .slab_stall
  );

  trav_decide #(.DEC_DEPTH(DEC_DEPTH)) decide_i (
    .clk, .rst_n,
    .slab_valid, .slab_data, .slab_stall,
    .stack_valid, .stack_data, .stack_stall,
    .next_valid, .next_data, .next_stall
  );

endmodule

//--- sync_fifo.sv
//--------------------------------------------------
// synchronous FIFO
// circular buffer with occupancy count, head
// entry always visible on rd_data
//--------------------------------------------------
module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             full,
  output logic             empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;

  assign full    = (count == CW'(DEPTH));
  assign empty   = (count == '0);
  assign rd_data = mem[rd_ptr];  // oldest entry

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // none, or both on one edge
      endcase
    end
  end

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    rd_en |-> !empty);
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en && full |-> rd_en);

endmodule

//--- tb_clk_gen.sv
//--------------------------------------------------
// testbench clock and reset
// free-running clock, reset held low for a few
// cycles and released on a rising edge
//--------------------------------------------------
module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;  // released with the edge
  end

endmodule

//--- trav_decide.sv
//--------------------------------------------------
// traversal decision
// queues slab results, applies empty-child rules,
// drives stack command and next-node request
//--------------------------------------------------
module trav_decide #(
  parameter int DEC_DEPTH = 8
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    slab_valid,
  input  kd_trav_pkg::slab_res_t  slab_data,
  output logic                    slab_stall,
  output logic                    stack_valid,
  output kd_trav_pkg::stack_cmd_t stack_data,
  input  logic                    stack_stall,
  output logic                    next_valid,
  output kd_trav_pkg::next_node_t next_data,
  input  logic                    next_stall
);
  import kd_trav_pkg::*;

  slab_res_t head;
  logic      dec_we;
  logic      dec_re;
  logic      dec_full;
  logic      dec_empty;
  node_id_t  low_id;
  node_id_t  high_id;
  node_id_t  far_id;
  node_id_t  next_id;
  fix_t      next_t_min;
  fix_t      next_t_max;
  ray_info_t next_ray;
  logic      pop;
  logic      push;
  logic      need_stack;
  logic      need_next;

  assign slab_stall = dec_full;
  assign dec_we     = slab_valid & ~dec_full;

  sync_fifo #(.WIDTH($bits(slab_res_t)), .DEPTH(DEC_DEPTH)) dec_q (
    .clk,
    .rst_n,
    .wr_en   (dec_we),
    .wr_data (slab_data),
    .rd_en   (dec_re),
    .rd_data (head),
    .full    (dec_full),
    .empty   (dec_empty)
  );

  //--------------------------------------------------
  // child selection
  //--------------------------------------------------
  assign low_id     = head.parent_id + 1'b1;  // low child stored right after parent
  assign high_id    = head.right_id;
  assign far_id     = head.lo_then_hi ? high_id : low_id;
  assign pop        = (head.only_low & head.low_empty) | (head.only_high & head.high_empty);
  assign push       = (head.lo_then_hi | head.hi_then_lo) & ~head.low_empty & ~head.high_empty;
  assign need_stack = pop | push;
  assign need_next  = ~pop;

  always_comb begin
    next_id    = low_id;
    next_t_min = head.t_min;
    next_t_max = head.t_max;
    if (head.only_high) begin
      next_id = high_id;
    end else if (head.lo_then_hi) begin
      if (head.low_empty) begin
        next_id    = high_id;     // far half only
        next_t_min = head.t_mid;
      end else begin
        next_t_max = head.t_mid;
      end
    end else if (head.hi_then_lo) begin
      if (head.high_empty) begin
        next_t_min = head.t_mid;  // low is the far half
      end else begin
        next_id    = high_id;
        next_t_max = head.t_mid;
      end
    end
  end

  always_comb begin
    next_ray = head.ray_info;
    if (push && (head.ray_info.ss_num < SS_DEPTH_MAX)) next_ray.ss_num = head.ray_info.ss_num + 3'd1;
  end

  // pop the head only if every output it feeds can take it
  assign dec_re = ~dec_empty &
                  (~need_stack | ~stack_valid | ~stack_stall) &
                  (~need_next | ~next_valid | ~next_stall);

  //--------------------------------------------------
  // output registers
  //--------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stack_valid <= 1'b0;
      next_valid  <= 1'b0;
    end else begin
      stack_valid <= (stack_valid & stack_stall) | (dec_re & need_stack);
      next_valid  <= (next_valid & next_stall) | (dec_re & need_next);
    end
  end

  always_ff @(posedge clk) begin
    if (dec_re && need_stack) begin
      stack_data.ray_info     <= head.ray_info;  // depth before the push
      stack_data.push_req     <= push;
      stack_data.pop_req      <= pop;
      stack_data.push_node_id <= far_id;
      stack_data.push_t_min   <= head.t_mid;
      stack_data.push_t_max   <= head.t_max;
    end
    if (dec_re && need_next) begin
      next_data.ray_info <= next_ray;
      next_data.node_id  <= next_id;
      next_data.t_min    <= next_t_min;
      next_data.t_max    <= next_t_max;
    end
  end

  // flags come from the slab stage, ranges and empty bits from the fetch
  a_case_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    !dec_empty |-> $onehot({head.only_low, head.only_high, head.lo_then_hi, head.hi_then_lo}));
  a_t_range: assert property (@(posedge clk) disable iff (!rst_n)
    !dec_empty |-> head.t_max > head.t_min);
  a_not_both_empty: assert property (@(posedge clk) disable iff (!rst_n)
    !dec_empty |-> !(head.low_empty && head.high_empty));

endmodule

//--- trav_node_dispatch.sv
//--------------------------------------------------
// traversal dispatch
// leaves go through a queue to a registered leaf
// output, inner nodes pass on to the slab stage
//--------------------------------------------------
module trav_node_dispatch #(
  parameter int LEAF_DEPTH = 8
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   node_valid,
  input  kd_trav_pkg::node_req_t node_data,
  output logic                   node_stall,
  output logic                   inner_valid,
  output kd_trav_pkg::node_req_t inner_data,
  input  logic                   inner_stall,
  output logic                   leaf_valid,
  output kd_trav_pkg::leaf_out_t leaf_data,
  input  logic                   leaf_stall
);
  import kd_trav_pkg::*;

  leaf_node_t leaf_view;
  leaf_out_t  leaf_in;
  leaf_out_t  leaf_head;
  logic       is_leaf;
  logic       leaf_we;
  logic       leaf_re;
  logic       leaf_full;
  logic       leaf_empty;

  assign leaf_view = node_data.node.leaf;
  assign is_leaf   = (leaf_view.node_type == NODE_LEAF);

  // stall follows whichever path this node takes
  assign node_stall  = node_valid & (is_leaf ? leaf_full : inner_stall);
  assign inner_valid = node_valid & ~is_leaf;
  assign inner_data  = node_data;
  assign leaf_we     = node_valid & is_leaf & ~leaf_full;

  always_comb begin
    leaf_in.ray_info  = node_data.ray_info;
    leaf_in.tri_ptr   = leaf_view.tri_ptr;
    leaf_in.tri_count = leaf_view.tri_count;
    leaf_in.t_max     = node_data.t_max;
  end

  sync_fifo #(.WIDTH($bits(leaf_out_t)), .DEPTH(LEAF_DEPTH)) leaf_q (
    .clk,
    .rst_n,
    .wr_en   (leaf_we),
    .wr_data (leaf_in),
    .rd_en   (leaf_re),
    .rd_data (leaf_head),
    .full    (leaf_full),
    .empty   (leaf_empty)
  );

  //--------------------------------------------------
  // leaf output register
  //--------------------------------------------------
  assign leaf_re = ~leaf_empty & (~leaf_valid | ~leaf_stall);

  always_ff @(posedge clk) begin
    if (!rst_n) leaf_valid <= 1'b0;
    else        leaf_valid <= (leaf_valid & leaf_stall) | leaf_re;
  end

  always_ff @(posedge clk) begin
    if (leaf_re) leaf_data <= leaf_head;  // held while stalled
  end

  // a leaf turned away by a full queue is offered again unchanged
  a_leaf_held_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    node_valid && is_leaf && leaf_full |=> node_valid && $stable(node_data));

endmodule

//--- trav_slab_math.sv
//--------------------------------------------------
// slab math, two stallable stages
// stage 1: split minus origin, near side
// stage 2: t_mid and traversal case flags
//--------------------------------------------------
module trav_slab_math (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   inner_valid,
  input  kd_trav_pkg::node_req_t inner_data,
  output logic                   inner_stall,
  output logic                   slab_valid,
  output kd_trav_pkg::slab_res_t slab_data,
  input  logic                   slab_stall
);
  import kd_trav_pkg::*;

  typedef struct packed {
    ray_info_t ray_info;
    node_id_t  parent_id;
    node_id_t  right_id;
    logic      low_empty;
    logic      high_empty;
    fix_t      t_min;
    fix_t      t_max;
    fix_t      inv_dir;
    fix_wide_t diff;      // split - origin
    logic      near_low;  // low child is the near one
  } slab_s1_t;

  inner_node_t inner_view;
  slab_s1_t    s1_d;
  slab_s1_t    s1_q;
  logic        s1_valid;
  logic        advance;
  fix_t        t_mid;
  logic        only_near;
  logic        only_far;
  logic        both;
  slab_res_t   res;

  // whole pipe freezes on a stalled result
  assign advance     = ~(slab_valid & slab_stall);
  assign inner_stall = ~advance;

  assign inner_view = inner_data.node.inner;

  always_comb begin
    s1_d.ray_info   = inner_data.ray_info;
    s1_d.parent_id  = inner_data.node_id;
    s1_d.right_id   = inner_view.right_id;
    s1_d.low_empty  = inner_view.low_empty;
    s1_d.high_empty = inner_view.high_empty;
    s1_d.t_min      = inner_data.t_min;
    s1_d.t_max      = inner_data.t_max;
    s1_d.inv_dir    = inner_data.inv_dir;
    s1_d.diff       = fix_diff(inner_view.split, inner_data.origin);
    // on the plane itself the direction sign decides
    s1_d.near_low   = (inner_data.origin < inner_view.split) ||
                      ((inner_data.origin == inner_view.split) && !inner_data.inv_dir[15]);
  end

  //--------------------------------------------------
  // stage 2 decision
  //--------------------------------------------------
  always_comb begin
    t_mid     = fix_mul_sat(s1_q.diff, s1_q.inv_dir);
    only_near = (t_mid >= s1_q.t_max) || (t_mid < 16'sd0);
    only_far  = !only_near && (t_mid <= s1_q.t_min);
    both      = !only_near && !only_far;

    res.ray_info   = s1_q.ray_info;
    res.parent_id  = s1_q.parent_id;
    res.right_id   = s1_q.right_id;
    res.low_empty  = s1_q.low_empty;
    res.high_empty = s1_q.high_empty;
    res.t_min      = s1_q.t_min;
    res.t_mid      = t_mid;
    res.t_max      = s1_q.t_max;
    res.only_low   = s1_q.near_low ? only_near : only_far;
    res.only_high  = s1_q.near_low ? only_far : only_near;
    res.lo_then_hi = both && s1_q.near_low;
    res.hi_then_lo = both && !s1_q.near_low;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid   <= 1'b0;
      slab_valid <= 1'b0;
    end else if (advance) begin
      s1_valid   <= inner_valid;
      slab_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      s1_q      <= s1_d;
      slab_data <= res;
    end
  end

endmodule
